//--- ctl_pkg.sv
// ====================
// shared definitions for the configuration controller.
// holds the host memory map, the control flag bit positions,
// the firmware version and the delay table size.
// ====================

package ctl_pkg;

  typedef logic [15:0] word_t;

  // ====================
  // address layout
  // ====================
  localparam int DEPTH      = 16;
  localparam int DLY_ADDR_W = 4;
  localparam int REG_ADDR_W = 7;
  localparam int BUS_ADDR_W = 9;
  localparam int PAGE_W     = BUS_ADDR_W - REG_ADDR_W;

  // pages 2 and 3 are unmapped.
  localparam logic [PAGE_W-1:0] PAGE_MAIN  = 2'd0;
  localparam logic [PAGE_W-1:0] PAGE_DELAY = 2'd1;

  // ====================
  // register page
  // ====================
  localparam logic [REG_ADDR_W-1:0] ADDR_CTL_FLAG         = 7'h00;
  localparam logic [REG_ADDR_W-1:0] ADDR_FPGA_INFO        = 7'h01;
  localparam logic [REG_ADDR_W-1:0] ADDR_SYNC_TIME_0      = 7'h11;
  localparam logic [REG_ADDR_W-1:0] ADDR_SYNC_TIME_1      = 7'h12;
  localparam logic [REG_ADDR_W-1:0] ADDR_SYNC_TIME_2      = 7'h13;
  localparam logic [REG_ADDR_W-1:0] ADDR_SYNC_TIME_3      = 7'h14;
  localparam logic [REG_ADDR_W-1:0] ADDR_MOD_CYCLE        = 7'h20;
  localparam logic [REG_ADDR_W-1:0] ADDR_MOD_FREQ_DIV_0   = 7'h21;
  localparam logic [REG_ADDR_W-1:0] ADDR_MOD_FREQ_DIV_1   = 7'h22;
  localparam logic [REG_ADDR_W-1:0] ADDR_STEP_INTENSITY   = 7'h28;
  localparam logic [REG_ADDR_W-1:0] ADDR_STEP_PHASE       = 7'h29;
  localparam logic [REG_ADDR_W-1:0] ADDR_STM_CYCLE        = 7'h40;
  localparam logic [REG_ADDR_W-1:0] ADDR_STM_FREQ_DIV_0   = 7'h41;
  localparam logic [REG_ADDR_W-1:0] ADDR_STM_FREQ_DIV_1   = 7'h42;
  localparam logic [REG_ADDR_W-1:0] ADDR_SOUND_SPEED_0    = 7'h43;
  localparam logic [REG_ADDR_W-1:0] ADDR_SOUND_SPEED_1    = 7'h44;
  localparam logic [REG_ADDR_W-1:0] ADDR_STM_START_IDX    = 7'h45;
  localparam logic [REG_ADDR_W-1:0] ADDR_STM_FINISH_IDX   = 7'h46;
  localparam logic [REG_ADDR_W-1:0] ADDR_DEBUG_OUT_IDX    = 7'h50;
  localparam logic [REG_ADDR_W-1:0] ADDR_VERSION_MAJOR    = 7'h7E;
  localparam logic [REG_ADDR_W-1:0] ADDR_VERSION_MINOR    = 7'h7F;

  // bit positions within the control flag word.
  localparam int FLAG_FORCE_FAN          = 4;
  localparam int FLAG_OP_MODE            = 9;
  localparam int FLAG_STM_GAIN_MODE      = 10;
  localparam int FLAG_USE_STM_FINISH_IDX = 11;
  localparam int FLAG_USE_STM_START_IDX  = 12;
  localparam int FLAG_FORCE_FAN_EX       = 13;
  localparam int FLAG_SYNC               = 15;

  localparam logic [7:0] VERSION_MAJOR = 8'h8D;
  localparam logic [7:0] VERSION_MINOR = 8'h01;

  // cycles in one sequencer polling round.
  localparam int POLL_CYCLES = 15;

endpackage

//--- ctl_dp_ram.sv
// ====================
// two-port synchronous memory with registered reads.
// port a faces the host, port b the internal logic.
// a host write wins when both ports write one address.
// ====================

`timescale 1ns/1ns

module ctl_dp_ram #(
  parameter type word_t = logic [15:0],
  parameter int  ADDR_W = 7
) (
  input  logic              CLK,
  input  logic              a_en,
  input  logic              a_we,
  input  logic [ADDR_W-1:0] a_addr,
  input  word_t             a_wdata,
  output word_t             a_rdata,
  input  logic              b_we,
  input  logic [ADDR_W-1:0] b_addr,
  input  word_t             b_wdata,
  output word_t             b_rdata
);

  word_t mem [2**ADDR_W];
  logic  host_hit;

  // block RAM contents power up cleared.
  initial begin
    for (int i = 0; i < 2**ADDR_W; i++) begin
      mem[i] = '0;
    end
  end

  assign host_hit = a_en && a_we && (a_addr == b_addr);

  // both ports read the old word in a write cycle.
  always_ff @(posedge CLK) begin
    if (a_en) begin
      if (a_we) begin
        mem[a_addr] <= a_wdata;
      end
      a_rdata <= mem[a_addr];
    end
    if (b_we && !host_hit) begin
      mem[b_addr] <= b_wdata;
    end
    b_rdata <= mem[b_addr];
  end

endmodule

//--- ctl_bus_decode.sv
// ====================
// host bus page decode.
// turns the page bits into memory enables and returns the
// register page data one cycle after a read.
// ====================

`timescale 1ns/1ns

module ctl_bus_decode
  import ctl_pkg::*;
(
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  bus_en,
  input  logic [BUS_ADDR_W-1:0] bus_addr,
  input  word_t                 main_rdata,
  output logic                  main_en,
  output logic                  dly_en,
  output word_t                 bus_rdata
);

  logic [PAGE_W-1:0] page;
  logic [PAGE_W-1:0] rd_page;

  assign page    = bus_addr[BUS_ADDR_W-1:REG_ADDR_W];
  assign main_en = bus_en && (page == PAGE_MAIN);
  assign dly_en  = bus_en && (page == PAGE_DELAY);

  // the delay page is write only, so it starts out selected and reads zero.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rd_page <= PAGE_DELAY;
    end else if (bus_en) begin
      rd_page <= page;
    end
  end

  assign bus_rdata = (rd_page == PAGE_MAIN) ? main_rdata : '0;

endmodule

//--- ctl_reg_sequencer.sv
// ====================
// register page sequencer.
// writes the version words after reset, then polls the
// configuration words into the outputs, writes the thermal state
// back and serves sync requests raised by the host.
// ====================

`timescale 1ns/1ns

module ctl_reg_sequencer
  import ctl_pkg::*;
(
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  thermo,
  input  word_t                 seq_rdata,
  output logic                  seq_we,
  output logic [REG_ADDR_W-1:0] seq_addr,
  output word_t                 seq_wdata,
  output logic                  force_fan,
  output logic                  op_mode,
  output logic                  stm_gain_mode,
  output logic                  use_stm_start_idx,
  output logic                  use_stm_finish_idx,
  output word_t                 cycle_m,
  output logic [31:0]           freq_div_m,
  output word_t                 step_intensity,
  output word_t                 step_phase,
  output word_t                 cycle_stm,
  output logic [31:0]           freq_div_stm,
  output logic [31:0]           sound_speed,
  output word_t                 stm_start_idx,
  output word_t                 stm_finish_idx,
  output logic [7:0]            debug_output_idx,
  output logic [63:0]           ecat_sync_time,
  output logic                  sync_set
);

  typedef enum logic [1:0] {
    ST_VER_MINOR,
    ST_VER_MAJOR,
    ST_POLL,
    ST_SYNC
  } state_t;

  state_t      state;
  logic [3:0]  step;
  word_t       ctl_flag;
  logic        dbg_pending;
  logic [47:0] sync_buf;

  assign force_fan          = ctl_flag[FLAG_FORCE_FAN] | ctl_flag[FLAG_FORCE_FAN_EX];
  assign op_mode            = ctl_flag[FLAG_OP_MODE];
  assign stm_gain_mode      = ctl_flag[FLAG_STM_GAIN_MODE];
  assign use_stm_start_idx  = ctl_flag[FLAG_USE_STM_START_IDX];
  assign use_stm_finish_idx = ctl_flag[FLAG_USE_STM_FINISH_IDX];

  // ====================
  // a read issued in step n returns its data in step n + 2.
  // ====================
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state            <= ST_VER_MINOR;
      step             <= '0;
      seq_we           <= 1'b0;
      seq_addr         <= '0;
      seq_wdata        <= '0;
      ctl_flag         <= '0;
      dbg_pending      <= 1'b0;
      cycle_m          <= '0;
      freq_div_m       <= '0;
      step_intensity   <= '0;
      step_phase       <= '0;
      cycle_stm        <= '0;
      freq_div_stm     <= '0;
      sound_speed      <= '0;
      stm_start_idx    <= '0;
      stm_finish_idx   <= '0;
      debug_output_idx <= '0;
      ecat_sync_time   <= '0;
      sync_set         <= 1'b0;
    end else begin
      sync_set <= 1'b0;
      case (state)
        ST_VER_MINOR: begin
          seq_we    <= 1'b1;
          seq_addr  <= ADDR_VERSION_MINOR;
          seq_wdata <= {8'h00, VERSION_MINOR};
          state     <= ST_VER_MAJOR;
        end
        ST_VER_MAJOR: begin
          seq_addr  <= ADDR_VERSION_MAJOR;
          seq_wdata <= {8'hFF, VERSION_MAJOR};
          step      <= '0;
          state     <= ST_POLL;
        end
        ST_POLL: begin
          seq_we <= 1'b0;
          step   <= (step == 4'(POLL_CYCLES - 1)) ? '0 : step + 1'b1;
          case (step)
            4'd0: begin
              seq_addr    <= ADDR_CTL_FLAG;
              dbg_pending <= 1'b0;
              if (dbg_pending) begin
                debug_output_idx <= seq_rdata[7:0];
              end
            end
            4'd1: seq_addr <= ADDR_MOD_CYCLE;
            4'd2: begin
              ctl_flag <= seq_rdata;
              if (seq_rdata[FLAG_SYNC]) begin
                // clear the request in memory, then fetch the time.
                seq_we    <= 1'b1;
                seq_addr  <= ADDR_CTL_FLAG;
                seq_wdata <= seq_rdata & ~(word_t'(1) << FLAG_SYNC);
                step      <= '0;
                state     <= ST_SYNC;
              end else begin
                seq_addr <= ADDR_MOD_FREQ_DIV_0;
              end
            end
            4'd3: begin
              seq_addr <= ADDR_MOD_FREQ_DIV_1;
              cycle_m  <= seq_rdata;
            end
            4'd4: begin
              seq_addr         <= ADDR_STEP_INTENSITY;
              freq_div_m[15:0] <= seq_rdata;
            end
            4'd5: begin
              seq_addr          <= ADDR_STEP_PHASE;
              freq_div_m[31:16] <= seq_rdata;
            end
            4'd6: begin
              seq_addr       <= ADDR_STM_CYCLE;
              step_intensity <= seq_rdata;
            end
            4'd7: begin
              seq_addr   <= ADDR_STM_FREQ_DIV_0;
              step_phase <= seq_rdata;
            end
            4'd8: begin
              seq_addr  <= ADDR_STM_FREQ_DIV_1;
              cycle_stm <= seq_rdata;
            end
            4'd9: begin
              seq_addr           <= ADDR_SOUND_SPEED_0;
              freq_div_stm[15:0] <= seq_rdata;
            end
            4'd10: begin
              seq_addr            <= ADDR_SOUND_SPEED_1;
              freq_div_stm[31:16] <= seq_rdata;
            end
            4'd11: begin
              seq_addr          <= ADDR_STM_START_IDX;
              sound_speed[15:0] <= seq_rdata;
            end
            4'd12: begin
              seq_addr           <= ADDR_STM_FINISH_IDX;
              sound_speed[31:16] <= seq_rdata;
            end
            4'd13: begin
              // this read lands in step 0 of the next round.
              seq_addr      <= ADDR_DEBUG_OUT_IDX;
              dbg_pending   <= 1'b1;
              stm_start_idx <= seq_rdata;
            end
            4'd14: begin
              seq_we         <= 1'b1;
              seq_addr       <= ADDR_FPGA_INFO;
              seq_wdata      <= word_t'(thermo);
              stm_finish_idx <= seq_rdata;
            end
            default: step <= '0;
          endcase
        end
        ST_SYNC: begin
          seq_we <= 1'b0;
          step   <= step + 1'b1;
          case (step)
            4'd0: seq_addr <= ADDR_SYNC_TIME_0;
            4'd1: seq_addr <= ADDR_SYNC_TIME_1;
            4'd2: seq_addr <= ADDR_SYNC_TIME_2;
            4'd3: seq_addr <= ADDR_SYNC_TIME_3;
            4'd5: begin
              ecat_sync_time <= {seq_rdata, sync_buf};
              sync_set       <= 1'b1;
              step           <= '0;
              state          <= ST_POLL;
            end
            default: begin
            end
          endcase
        end
        default: state <= ST_VER_MINOR;
      endcase
    end
  end

  // lower sync time words wait here so the time updates in one step.
  always_ff @(posedge CLK) begin
    if (state == ST_SYNC) begin
      case (step)
        4'd2: sync_buf[15:0]  <= seq_rdata;
        4'd3: sync_buf[31:16] <= seq_rdata;
        4'd4: sync_buf[47:32] <= seq_rdata;
        default: begin
        end
      endcase
    end
  end

endmodule

//--- ctl_delay_scanner.sv
// ====================
// delay table scanner.
// walks the delay page one entry per cycle and copies each
// word into the delay output array.
// ====================

`timescale 1ns/1ns

module ctl_delay_scanner
  import ctl_pkg::*;
(
  input  logic                  CLK,
  input  logic                  arst_n,
  input  word_t                 dly_rdata,
  output logic [DLY_ADDR_W-1:0] dly_addr,
  output word_t                 delay_m [DEPTH]
);

  logic [DLY_ADDR_W-1:0] rd_ptr;
  logic [DLY_ADDR_W-1:0] ld_ptr;

  assign dly_addr = rd_ptr;

  // the memory answers one cycle late, so the load pointer is
  // simply the read pointer of the previous cycle.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
      ld_ptr <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        delay_m[i] <= '0;
      end
    end else begin
      rd_ptr          <= (rd_ptr == DLY_ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      ld_ptr          <= rd_ptr;
      delay_m[ld_ptr] <= dly_rdata;
    end
  end

endmodule

//--- ctl_top.sv
// ====================
// configuration controller top level.
// the host bus feeds a register page and a delay page. the
// sequencer and the scanner turn them into registered outputs.
// ====================

`timescale 1ns/1ns

module ctl_top
  import ctl_pkg::*;
(
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  bus_en,
  input  logic                  bus_we,
  input  logic [BUS_ADDR_W-1:0] bus_addr,
  input  word_t                 bus_wdata,
  output word_t                 bus_rdata,
  input  logic                  thermo,
  output logic                  force_fan,
  output logic                  op_mode,
  output logic                  stm_gain_mode,
  output logic                  use_stm_start_idx,
  output logic                  use_stm_finish_idx,
  output word_t                 cycle_m,
  output logic [31:0]           freq_div_m,
  output word_t                 step_intensity,
  output word_t                 step_phase,
  output word_t                 cycle_stm,
  output logic [31:0]           freq_div_stm,
  output logic [31:0]           sound_speed,
  output word_t                 stm_start_idx,
  output word_t                 stm_finish_idx,
  output logic [7:0]            debug_output_idx,
  output logic [63:0]           ecat_sync_time,
  output logic                  sync_set,
  output word_t                 delay_m [DEPTH]
);

  logic                  main_en;
  logic                  dly_en;
  word_t                 main_rdata;
  logic                  seq_we;
  logic [REG_ADDR_W-1:0] seq_addr;
  word_t                 seq_wdata;
  word_t                 seq_rdata;
  logic [DLY_ADDR_W-1:0] dly_addr;
  word_t                 dly_rdata;

  ctl_bus_decode u_bus_decode (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .bus_en     (bus_en),
    .bus_addr   (bus_addr),
    .main_rdata (main_rdata),
    .main_en    (main_en),
    .dly_en     (dly_en),
    .bus_rdata  (bus_rdata)
  );

  ctl_dp_ram #(.word_t(word_t), .ADDR_W(REG_ADDR_W)) reg_ram (
    .CLK     (CLK),
    .a_en    (main_en),
    .a_we    (bus_we),
    .a_addr  (bus_addr[REG_ADDR_W-1:0]),
    .a_wdata (bus_wdata),
    .a_rdata (main_rdata),
    .b_we    (seq_we),
    .b_addr  (seq_addr),
    .b_wdata (seq_wdata),
    .b_rdata (seq_rdata)
  );

  // the host side of the delay page is write only.
  ctl_dp_ram #(.word_t(word_t), .ADDR_W(DLY_ADDR_W)) dly_ram (
    .CLK     (CLK),
    .a_en    (dly_en),
    .a_we    (bus_we),
    .a_addr  (bus_addr[DLY_ADDR_W-1:0]),
    .a_wdata (bus_wdata),
    .a_rdata (),
    .b_we    (1'b0),
    .b_addr  (dly_addr),
    .b_wdata ('0),
    .b_rdata (dly_rdata)
  );

  ctl_reg_sequencer u_sequencer (
    .CLK                (CLK),
    .arst_n             (arst_n),
    .thermo             (thermo),
    .seq_rdata          (seq_rdata),
    .seq_we             (seq_we),
    .seq_addr           (seq_addr),
    .seq_wdata          (seq_wdata),
    .force_fan          (force_fan),
    .op_mode            (op_mode),
    .stm_gain_mode      (stm_gain_mode),
    .use_stm_start_idx  (use_stm_start_idx),
    .use_stm_finish_idx (use_stm_finish_idx),
    .cycle_m            (cycle_m),
    .freq_div_m         (freq_div_m),
    .step_intensity     (step_intensity),
    .step_phase         (step_phase),
    .cycle_stm          (cycle_stm),
    .freq_div_stm       (freq_div_stm),
    .sound_speed        (sound_speed),
    .stm_start_idx      (stm_start_idx),
    .stm_finish_idx     (stm_finish_idx),
    .debug_output_idx   (debug_output_idx),
    .ecat_sync_time     (ecat_sync_time),
    .sync_set           (sync_set)
  );

  ctl_delay_scanner u_delay_scanner (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .dly_rdata (dly_rdata),
    .dly_addr  (dly_addr),
    .delay_m   (delay_m)
  );

endmodule

//--- ctl_checker.sv
// ====================
// protocol assertions for the configuration controller.
// bound into the top level, where the sequencer and the bus
// decode wires are both visible.
// ====================

`timescale 1ns/1ns

module ctl_checker (
  input logic CLK,
  input logic arst_n,
  input logic sync_set,
  input logic seq_we,
  input logic main_en,
  input logic dly_en
);

  // the testbench reads this count at the end of the run.
  int fail_count = 0;

  sync_single_pulse: assert property (
    @(posedge CLK) disable iff (!arst_n) sync_set |=> !sync_set
  ) else begin
    $error("sync_set was high for two cycles in a row");
    fail_count++;
  end

  no_write_after_reset: assert property (
    @(posedge CLK) $rose(arst_n) |-> !seq_we
  ) else begin
    $error("seq_we was high in the first cycle after reset release");
    fail_count++;
  end

  one_page_enable: assert property (
    @(posedge CLK) disable iff (!arst_n) !(main_en && dly_en)
  ) else begin
    $error("both memory enables were high in one cycle");
    fail_count++;
  end

endmodule

bind ctl_top ctl_checker u_checker (
  .CLK      (CLK),
  .arst_n   (arst_n),
  .sync_set (sync_set),
  .seq_we   (seq_we),
  .main_en  (main_en),
  .dly_en   (dly_en)
);

//--- ctl_tb.sv
// ====================
// testbench for the configuration controller.
// drives random host traffic from an LFSR, keeps a model of both
// memory pages and compares the registered outputs against it.
// ====================

`timescale 1ns/1ns

module ctl_tb
  import ctl_pkg::*;
();

  logic                  CLK;
  logic                  arst_n;
  logic                  bus_en;
  logic                  bus_we;
  logic [BUS_ADDR_W-1:0] bus_addr;
  word_t                 bus_wdata;
  word_t                 bus_rdata;
  logic                  thermo;
  logic                  force_fan;
  logic                  op_mode;
  logic                  stm_gain_mode;
  logic                  use_stm_start_idx;
  logic                  use_stm_finish_idx;
  word_t                 cycle_m;
  logic [31:0]           freq_div_m;
  word_t                 step_intensity;
  word_t                 step_phase;
  word_t                 cycle_stm;
  logic [31:0]           freq_div_stm;
  logic [31:0]           sound_speed;
  word_t                 stm_start_idx;
  word_t                 stm_finish_idx;
  logic [7:0]            debug_output_idx;
  logic [63:0]           ecat_sync_time;
  logic                  sync_set;
  word_t                 delay_m [DEPTH];

  logic [15:0] lfsr_state;
  word_t       model_mem [2**REG_ADDR_W];
  word_t       model_dly [DEPTH];
  logic [63:0] model_sync_time;

  ctl_top DUT (
    .CLK                (CLK),
    .arst_n             (arst_n),
    .bus_en             (bus_en),
    .bus_we             (bus_we),
    .bus_addr           (bus_addr),
    .bus_wdata          (bus_wdata),
    .bus_rdata          (bus_rdata),
    .thermo             (thermo),
    .force_fan          (force_fan),
    .op_mode            (op_mode),
    .stm_gain_mode      (stm_gain_mode),
    .use_stm_start_idx  (use_stm_start_idx),
    .use_stm_finish_idx (use_stm_finish_idx),
    .cycle_m            (cycle_m),
    .freq_div_m         (freq_div_m),
    .step_intensity     (step_intensity),
    .step_phase         (step_phase),
    .cycle_stm          (cycle_stm),
    .freq_div_stm       (freq_div_stm),
    .sound_speed        (sound_speed),
    .stm_start_idx      (stm_start_idx),
    .stm_finish_idx     (stm_finish_idx),
    .debug_output_idx   (debug_output_idx),
    .ecat_sync_time     (ecat_sync_time),
    .sync_set           (sync_set),
    .delay_m            (delay_m)
  );

  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  // ====================
  // random numbers
  // ====================
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // ====================
  // checks
  // ====================
  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_time(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    if (got !== exp) begin
      $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: time %0t %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // assertion failures in the bound checker end the run at once.
  always @(negedge CLK) begin
    if (DUT.u_checker.fail_count != 0) begin
      $display("a checker assertion failed before time %0t", $time);
      abort_run();
    end
  end

  // ====================
  // model of the outputs
  // ====================
  function automatic logic [31:0] model_pair(input logic [REG_ADDR_W-1:0] lo,
                                             input logic [REG_ADDR_W-1:0] hi);
    return {model_mem[hi], model_mem[lo]};
  endfunction

  function automatic logic model_fan();
    word_t f;
    f = model_mem[ADDR_CTL_FLAG];
    return f[FLAG_FORCE_FAN] | f[FLAG_FORCE_FAN_EX];
  endfunction

  function automatic logic outputs_match();
    word_t f;
    f = model_mem[ADDR_CTL_FLAG];
    return (force_fan === model_fan()) && (op_mode === f[FLAG_OP_MODE]) &&
      (stm_gain_mode === f[FLAG_STM_GAIN_MODE]) &&
      (use_stm_start_idx === f[FLAG_USE_STM_START_IDX]) &&
      (use_stm_finish_idx === f[FLAG_USE_STM_FINISH_IDX]) &&
      (cycle_m === model_mem[ADDR_MOD_CYCLE]) &&
      (freq_div_m === model_pair(ADDR_MOD_FREQ_DIV_0, ADDR_MOD_FREQ_DIV_1)) &&
      (step_intensity === model_mem[ADDR_STEP_INTENSITY]) &&
      (step_phase === model_mem[ADDR_STEP_PHASE]) &&
      (cycle_stm === model_mem[ADDR_STM_CYCLE]) &&
      (freq_div_stm === model_pair(ADDR_STM_FREQ_DIV_0, ADDR_STM_FREQ_DIV_1)) &&
      (sound_speed === model_pair(ADDR_SOUND_SPEED_0, ADDR_SOUND_SPEED_1)) &&
      (stm_start_idx === model_mem[ADDR_STM_START_IDX]) &&
      (stm_finish_idx === model_mem[ADDR_STM_FINISH_IDX]) &&
      (debug_output_idx === model_mem[ADDR_DEBUG_OUT_IDX][7:0]) &&
      (ecat_sync_time === model_sync_time) && (sync_set === 1'b0);
  endfunction

  task automatic check_outputs();
    word_t f;
    logic [31:0] fm;
    logic [31:0] fs;
    logic [31:0] ss;
    f  = model_mem[ADDR_CTL_FLAG];
    fm = model_pair(ADDR_MOD_FREQ_DIV_0, ADDR_MOD_FREQ_DIV_1);
    fs = model_pair(ADDR_STM_FREQ_DIV_0, ADDR_STM_FREQ_DIV_1);
    ss = model_pair(ADDR_SOUND_SPEED_0, ADDR_SOUND_SPEED_1);
    check_bit("force_fan", force_fan, model_fan());
    check_bit("op_mode", op_mode, f[FLAG_OP_MODE]);
    check_bit("stm_gain_mode", stm_gain_mode, f[FLAG_STM_GAIN_MODE]);
    check_bit("use_stm_start_idx", use_stm_start_idx, f[FLAG_USE_STM_START_IDX]);
    check_bit("use_stm_finish_idx", use_stm_finish_idx, f[FLAG_USE_STM_FINISH_IDX]);
    check_word("cycle_m", cycle_m, model_mem[ADDR_MOD_CYCLE]);
    check_word("freq_div_m[15:0]", freq_div_m[15:0], fm[15:0]);
    check_word("freq_div_m[31:16]", freq_div_m[31:16], fm[31:16]);
    check_word("step_intensity", step_intensity, model_mem[ADDR_STEP_INTENSITY]);
    check_word("step_phase", step_phase, model_mem[ADDR_STEP_PHASE]);
    check_word("cycle_stm", cycle_stm, model_mem[ADDR_STM_CYCLE]);
    check_word("freq_div_stm[15:0]", freq_div_stm[15:0], fs[15:0]);
    check_word("freq_div_stm[31:16]", freq_div_stm[31:16], fs[31:16]);
    check_word("sound_speed[15:0]", sound_speed[15:0], ss[15:0]);
    check_word("sound_speed[31:16]", sound_speed[31:16], ss[31:16]);
    check_word("stm_start_idx", stm_start_idx, model_mem[ADDR_STM_START_IDX]);
    check_word("stm_finish_idx", stm_finish_idx, model_mem[ADDR_STM_FINISH_IDX]);
    check_word("debug_output_idx", word_t'(debug_output_idx),
               {8'h00, model_mem[ADDR_DEBUG_OUT_IDX][7:0]});
    check_time("ecat_sync_time", ecat_sync_time, model_sync_time);
    check_bit("sync_set", sync_set, 1'b0);
  endtask

  function automatic logic delays_match();
    for (int i = 0; i < DEPTH; i++) begin
      if (delay_m[i] !== model_dly[i]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // the outputs trail the memory, so every wait polls with a limit.
  task automatic wait_outputs(input int limit);
    int n;
    n = 0;
    while (!outputs_match() && n < limit) begin
      @(negedge CLK);
      n++;
    end
    check_outputs();
  endtask

  task automatic wait_delays(input int limit);
    int n;
    n = 0;
    while (!delays_match() && n < limit) begin
      @(negedge CLK);
      n++;
    end
    for (int i = 0; i < DEPTH; i++) begin
      check_word($sformatf("delay_m[%0d]", i), delay_m[i], model_dly[i]);
    end
  endtask

  // ====================
  // host bus, called at a falling edge
  // ====================
  task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input word_t data);
    bus_en    = 1'b1;
    bus_we    = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    @(negedge CLK);
    bus_en = 1'b0;
    bus_we = 1'b0;
  endtask

  task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr, output word_t data);
    bus_en   = 1'b1;
    bus_we   = 1'b0;
    bus_addr = addr;
    @(negedge CLK);
    data   = bus_rdata;
    bus_en = 1'b0;
  endtask

  task automatic host_set(input logic [REG_ADDR_W-1:0] addr, input word_t data);
    model_mem[addr] = data;
    bus_write({PAGE_MAIN, addr}, data);
  endtask

  task automatic read_until(input logic [REG_ADDR_W-1:0] addr, input word_t exp,
                            input word_t mask, input int limit, output word_t got);
    int n;
    n = 0;
    bus_read({PAGE_MAIN, addr}, got);
    while (((got & mask) !== (exp & mask)) && n < limit) begin
      bus_read({PAGE_MAIN, addr}, got);
      n++;
    end
  endtask

  function automatic logic [REG_ADDR_W-1:0] cfg_addr(input int i);
    case (i)
      0:       return ADDR_MOD_CYCLE;
      1:       return ADDR_MOD_FREQ_DIV_0;
      2:       return ADDR_MOD_FREQ_DIV_1;
      3:       return ADDR_STEP_INTENSITY;
      4:       return ADDR_STEP_PHASE;
      5:       return ADDR_STM_CYCLE;
      6:       return ADDR_STM_FREQ_DIV_0;
      7:       return ADDR_STM_FREQ_DIV_1;
      8:       return ADDR_SOUND_SPEED_0;
      9:       return ADDR_SOUND_SPEED_1;
      10:      return ADDR_STM_START_IDX;
      11:      return ADDR_STM_FINISH_IDX;
      default: return ADDR_DEBUG_OUT_IDX;
    endcase
  endfunction

  task automatic run_sync();
    logic [63:0] t;
    word_t       flag;
    word_t       got;
    int          n;
    int          pulses;
    t    = rand_bits(64);
    flag = word_t'(rand_bits(16)) | (word_t'(1) << FLAG_SYNC);
    host_set(ADDR_SYNC_TIME_0, t[15:0]);
    host_set(ADDR_SYNC_TIME_1, t[31:16]);
    host_set(ADDR_SYNC_TIME_2, t[47:32]);
    host_set(ADDR_SYNC_TIME_3, t[63:48]);
    host_set(ADDR_CTL_FLAG, flag);
    n = 0;
    while (sync_set !== 1'b1 && n < 3 * POLL_CYCLES) begin
      @(negedge CLK);
      n++;
    end
    if (sync_set !== 1'b1) begin
      $display("sync_set never pulsed after the host set the sync flag");
      abort_run();
    end
    model_sync_time = t;
    model_mem[ADDR_CTL_FLAG] = flag & ~(word_t'(1) << FLAG_SYNC);
    check_time("ecat_sync_time", ecat_sync_time, model_sync_time);
    pulses = 0;
    for (n = 0; n < 2 * POLL_CYCLES; n++) begin
      @(negedge CLK);
      if (sync_set === 1'b1) begin
        pulses++;
      end
    end
    if (pulses != 0) begin
      $display("sync_set pulsed again after a single sync request");
      abort_run();
    end
    bus_read({PAGE_MAIN, ADDR_CTL_FLAG}, got);
    check_word("ctl_flag word", got, model_mem[ADDR_CTL_FLAG]);
  endtask

  // ====================
  // test sequence
  // ====================
  initial begin
    word_t                 got;
    logic [DLY_ADDR_W-1:0] idx;
    logic [REG_ADDR_W-1:0] a;
    word_t                 d;
    lfsr_state      = 16'd16472;
    arst_n          = 1'b0;
    bus_en          = 1'b0;
    bus_we          = 1'b0;
    bus_addr        = '0;
    bus_wdata       = '0;
    thermo          = 1'b0;
    model_sync_time = '0;
    for (int i = 0; i < 2**REG_ADDR_W; i++) begin
      model_mem[i] = '0;
    end
    for (int i = 0; i < DEPTH; i++) begin
      model_dly[i] = '0;
    end
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;

    // reset values and firmware version.
    check_outputs();
    wait_delays(0);
    read_until(ADDR_VERSION_MINOR, {8'h00, VERSION_MINOR}, 16'hFFFF, 10, got);
    check_word("version minor", got, {8'h00, VERSION_MINOR});
    read_until(ADDR_VERSION_MAJOR, {8'hFF, VERSION_MAJOR}, 16'hFFFF, 10, got);
    check_word("version major", got, {8'hFF, VERSION_MAJOR});

    // configuration words.
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < 13; i++) begin
        host_set(cfg_addr(i), word_t'(rand_bits(16)));
      end
      wait_outputs(2 * POLL_CYCLES + 4);
    end

    // each fan bit alone must raise force_fan.
    host_set(ADDR_CTL_FLAG, word_t'(1) << FLAG_FORCE_FAN);
    wait_outputs(2 * POLL_CYCLES + 4);
    host_set(ADDR_CTL_FLAG, word_t'(1) << FLAG_FORCE_FAN_EX);
    wait_outputs(2 * POLL_CYCLES + 4);

    // control flags, with the sync request kept clear.
    for (int r = 0; r < 8; r++) begin
      host_set(ADDR_CTL_FLAG, word_t'(rand_bits(16)) & ~(word_t'(1) << FLAG_SYNC));
      wait_outputs(2 * POLL_CYCLES + 4);
    end

    // thermal state.
    for (int r = 0; r < 6; r++) begin
      thermo = 1'(rand_bits(1));
      read_until(ADDR_FPGA_INFO, word_t'(thermo), 16'h0001, 2 * POLL_CYCLES + 4, got);
      check_bit("fpga_info[0]", got[0], thermo);
    end

    for (int r = 0; r < 2; r++) begin
      run_sync();
      wait_outputs(2 * POLL_CYCLES + 4);
    end

    // delay page and unmapped pages.
    for (int r = 0; r < 24; r++) begin
      idx = DLY_ADDR_W'(rand_bits(DLY_ADDR_W));
      d   = word_t'(rand_bits(16));
      model_dly[idx] = d;
      bus_write({PAGE_DELAY, REG_ADDR_W'(idx)}, d);
    end
    wait_delays(2 * DEPTH + 3);
    for (int r = 0; r < 4; r++) begin
      bus_read({PAGE_DELAY, REG_ADDR_W'(rand_bits(DLY_ADDR_W))}, got);
      check_word("delay page read", got, '0);
      a = cfg_addr(r);
      bus_write({2'd2 + 2'(r & 1), a}, word_t'(rand_bits(16)));
      bus_read({2'd2 + 2'(r & 1), a}, got);
      check_word("unmapped page read", got, '0);
      bus_read({PAGE_MAIN, a}, got);
      check_word("main word after unmapped write", got, model_mem[a]);
    end
    wait_outputs(2 * POLL_CYCLES + 4);
    wait_delays(2 * DEPTH + 3);

    if (DUT.u_checker.fail_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("%0d assertion failures in the checker", DUT.u_checker.fail_count);
      abort_run();
    end
  end

endmodule

//--- files.f
ctl_pkg.sv
ctl_dp_ram.sv
ctl_bus_decode.sv
ctl_reg_sequencer.sv
ctl_delay_scanner.sv
ctl_top.sv
ctl_checker.sv
ctl_tb.sv
